/* dv/tb_sw_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sw_reg_bank;
  import sw_reg_pkg::*;

  localparam logic [DATA_W-1:0] CTRL0_INIT = 32'h1357_9BDF;
  localparam logic [DATA_W-1:0] CTRL1_INIT = 32'h2468_ACE0;
  localparam logic [DATA_W-1:0] STAT0_INIT = 32'hDEAD_0001;
  localparam logic [DATA_W-1:0] STAT1_INIT = 32'hBEEF_0002;

  // run budget of 200 transactions at 40 bus clock cycles each
  localparam int MAX_CYCLES = 200 * 40;
  localparam int RESP_LIMIT = 16;

  logic              user_clk;
  logic              wb_clk_i;
  logic              wb_rst_i;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic              wb_we_i;
  logic [ADDR_W-1:0] wb_adr_i;
  sel_t              wb_sel_i;
  logic [DATA_W-1:0] wb_dat_i;
  logic [DATA_W-1:0] wb_dat_o;
  logic              wb_ack_o;
  logic              wb_err_o;
  logic [DATA_W-1:0] ctrl0_o;
  logic [DATA_W-1:0] ctrl1_o;
  logic [DATA_W-1:0] stat0_i;
  logic [DATA_W-1:0] stat1_i;

  // reference model of the bank
  logic [DATA_W-1:0] ctrl_model [2];
  logic [DATA_W-1:0] stat_model [2];

  int wb_cycles    = 0;
  int checks       = 0;
  int value_errors = 0;
  int other_errors = 0;

  sw_reg_bank_top #(
    .CTRL0_INIT (CTRL0_INIT),
    .CTRL1_INIT (CTRL1_INIT),
    .STAT0_INIT (STAT0_INIT),
    .STAT1_INIT (STAT1_INIT)
  ) i_sw_reg_bank_top (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .user_clk (user_clk),
    .ctrl0_o  (ctrl0_o),
    .ctrl1_o  (ctrl1_o),
    .stat0_i  (stat0_i),
    .stat1_i  (stat1_i)
  );

  initial begin
    user_clk = 1'b0;
    forever #20 user_clk = ~user_clk;
  end

  initial begin
    wb_clk_i = 1'b0;
    forever #12.5 wb_clk_i = ~wb_clk_i;
  end

  task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                            input logic [DATA_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
    end
  endtask

  // byte lane merge as a bus write defines it
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input sel_t sel);
    logic [DATA_W-1:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic [ADDR_W-1:0] ctrl_addr(input logic idx);
    return idx ? ADR_CTRL1 : ADR_CTRL0;
  endfunction

  function automatic logic [ADDR_W-1:0] stat_addr(input logic idx);
    return idx ? ADR_STAT1 : ADR_STAT0;
  endfunction

  // one request with the strobe held until ack or err
  task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr, input sel_t sel,
                            input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat,
                            output logic got_ack, output logic got_err);
    int waited;
    waited = 0;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_sel_i <= sel;
    wb_dat_i <= wdat;
    @(negedge wb_clk_i);
    while (!(wb_ack_o || wb_err_o) && waited < RESP_LIMIT) begin
      @(negedge wb_clk_i);
      waited++;
    end
    got_ack = wb_ack_o;
    got_err = wb_err_o;
    rdat    = wb_dat_o;
    if (!(got_ack || got_err)) begin
      other_errors++;
      $display("no ack or err within %0d cycles for address %h", RESP_LIMIT, adr);
    end
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    // a second pulse here would mean a repeated response
    @(negedge wb_clk_i);
    check_bit("wb_ack_o after release", 1'b0, wb_ack_o);
    check_bit("wb_err_o after release", 1'b0, wb_err_o);
  endtask

  task automatic write_word(input logic [ADDR_W-1:0] adr, input sel_t sel,
                            input logic [DATA_W-1:0] dat, input logic mapped);
    logic [DATA_W-1:0] rdat;
    logic              ack;
    logic              err;
    bus_access(1'b1, adr, sel, dat, rdat, ack, err);
    check_bit("wb_ack_o", mapped, ack);
    check_bit("wb_err_o", !mapped, err);
  endtask

  task automatic read_word(input logic [ADDR_W-1:0] adr, input logic mapped,
                           output logic [DATA_W-1:0] data);
    logic ack;
    logic err;
    bus_access(1'b0, adr, 4'hF, '0, data, ack, err);
    check_bit("wb_ack_o", mapped, ack);
    check_bit("wb_err_o", !mapped, err);
    if (!mapped) begin
      check_word("wb_dat_o", '0, data);
    end
  endtask

  // user outputs only move on the rising user clock
  task automatic check_ctrl_outputs();
    @(negedge user_clk);
    check_word("ctrl0_o", ctrl_model[0], ctrl0_o);
    check_word("ctrl1_o", ctrl_model[1], ctrl1_o);
  endtask

  task automatic print_counts();
    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
  endtask

  // bus outputs stay quiet in reset and never ack and err together
  always @(negedge wb_clk_i) begin
    if (wb_rst_i && wb_cycles > 2) begin
      check_bit("wb_ack_o in reset", 1'b0, wb_ack_o);
      check_bit("wb_err_o in reset", 1'b0, wb_err_o);
      check_word("wb_dat_o in reset", '0, wb_dat_o);
    end
    if (!wb_rst_i && wb_ack_o && wb_err_o) begin
      other_errors++;
      $display("ack and err were both high on the bus at %0t", $time);
    end
  end

  always @(posedge wb_clk_i) begin
    wb_cycles++;
    if (wb_cycles >= MAX_CYCLES) begin
      $display("simulation timed out after %0d bus clock cycles", wb_cycles);
      print_counts();
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    logic [DATA_W-1:0] rdat;
    logic [31:0]       r;
    logic [DATA_W-1:0] d;
    logic              idx;
    int                n_wr;
    void'($urandom(49962));
    wb_rst_i = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_sel_i = '0;
    wb_dat_i = '0;
    stat0_i  = STAT0_INIT;
    stat1_i  = STAT1_INIT;
    ctrl_model[0] = CTRL0_INIT;
    ctrl_model[1] = CTRL1_INIT;
    stat_model[0] = STAT0_INIT;
    stat_model[1] = STAT1_INIT;

    repeat (16) @(posedge user_clk);
    wb_rst_i <= 1'b0;
    repeat (2) @(posedge wb_clk_i);

    // reset values on the bus and on the user side
    read_word(ADR_CTRL0, 1'b1, rdat);
    check_word("read CTRL0", CTRL0_INIT, rdat);
    read_word(ADR_CTRL1, 1'b1, rdat);
    check_word("read CTRL1", CTRL1_INIT, rdat);
    read_word(ADR_STAT0, 1'b1, rdat);
    check_word("read STAT0", STAT0_INIT, rdat);
    read_word(ADR_STAT1, 1'b1, rdat);
    check_word("read STAT1", STAT1_INIT, rdat);
    check_ctrl_outputs();

    // single writes with random byte lanes
    for (int k = 0; k < 100; k++) begin
      r   = $urandom;
      d   = $urandom;
      idx = r[0];
      write_word(ctrl_addr(idx), r[7:4], d, 1'b1);
      ctrl_model[idx] = merge_bytes(ctrl_model[idx], d, r[7:4]);
      read_word(ctrl_addr(idx), 1'b1, rdat);
      check_word($sformatf("readback CTRL%0d", idx), ctrl_model[idx], rdat);
      repeat (4) @(posedge user_clk);
      repeat (2) @(posedge wb_clk_i);
      check_ctrl_outputs();
      // let the done level fall before the next write
      repeat (6) @(posedge user_clk);
    end

    // back-to-back writes while the crossing is still busy
    for (int g = 0; g < 16; g++) begin
      r    = $urandom;
      idx  = r[0];
      n_wr = 2 + r[3:2];
      for (int w = 0; w < n_wr; w++) begin
        r = $urandom;
        d = $urandom;
        write_word(ctrl_addr(idx), r[3:0], d, 1'b1);
        ctrl_model[idx] = merge_bytes(ctrl_model[idx], d, r[3:0]);
      end
      repeat (8) @(posedge user_clk);
      check_ctrl_outputs();
      read_word(ctrl_addr(idx), 1'b1, rdat);
      check_word($sformatf("readback CTRL%0d", idx), ctrl_model[idx], rdat);
    end

    // status words with bus writes that are ignored
    for (int k = 0; k < 16; k++) begin
      @(posedge user_clk);
      d = $urandom;
      stat0_i <= d;
      stat_model[0] = d;
      d = $urandom;
      stat1_i <= d;
      stat_model[1] = d;
      repeat (12) @(posedge user_clk);
      for (int s = 0; s < 2; s++) begin
        read_word(stat_addr(s[0]), 1'b1, rdat);
        check_word($sformatf("read STAT%0d", s), stat_model[s], rdat);
        r = $urandom;
        d = $urandom;
        write_word(stat_addr(s[0]), r[3:0], d, 1'b1);
        read_word(stat_addr(s[0]), 1'b1, rdat);
        check_word($sformatf("read STAT%0d after write", s), stat_model[s], rdat);
      end
    end

    // unmapped addresses get err and leave the bank alone
    for (int k = 0; k < 40; k++) begin
      r = $urandom;
      if (r[31:4] == 28'd0) begin
        r[4] = 1'b1;
      end
      d = $urandom;
      if (d[0]) begin
        write_word(r, d[7:4], $urandom, 1'b0);
      end else begin
        read_word(r, 1'b0, rdat);
      end
    end
    read_word(ADR_CTRL0, 1'b1, rdat);
    check_word("read CTRL0", ctrl_model[0], rdat);
    read_word(ADR_CTRL1, 1'b1, rdat);
    check_word("read CTRL1", ctrl_model[1], rdat);
    repeat (12) @(posedge user_clk);
    check_ctrl_outputs();

    print_counts();
    if (value_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/sw_reg_bank_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sw_reg_bank_top #(
  parameter logic [sw_reg_pkg::DATA_W-1:0] CTRL0_INIT = 32'h0000_00A5,
  parameter logic [sw_reg_pkg::DATA_W-1:0] CTRL1_INIT = 32'h0000_5A00,
  parameter logic [sw_reg_pkg::DATA_W-1:0] STAT0_INIT = 32'h00C3_0000,
  parameter logic [sw_reg_pkg::DATA_W-1:0] STAT1_INIT = 32'h3C00_0000
) (
  // bus side
  input  wire                           wb_clk_i,
  input  wire                           wb_rst_i,
  input  wire                           wb_cyc_i,
  input  wire                           wb_stb_i,
  input  wire                           wb_we_i,
  input  wire [sw_reg_pkg::ADDR_W-1:0]  wb_adr_i,
  input  wire sw_reg_pkg::sel_t         wb_sel_i,
  input  wire [sw_reg_pkg::DATA_W-1:0]  wb_dat_i,
  output logic [sw_reg_pkg::DATA_W-1:0] wb_dat_o,
  output logic                          wb_ack_o,
  output logic                          wb_err_o,
  // user side
  input  wire                           user_clk,
  output logic [sw_reg_pkg::DATA_W-1:0] ctrl0_o,
  output logic [sw_reg_pkg::DATA_W-1:0] ctrl1_o,
  input  wire [sw_reg_pkg::DATA_W-1:0]  stat0_i,
  input  wire [sw_reg_pkg::DATA_W-1:0]  stat1_i
);
  import sw_reg_pkg::*;

  // per register strobe, ack and read data
  logic [3:0]        reg_stb;
  logic [3:0]        reg_ack;
  logic [DATA_W-1:0] reg_dat0;
  logic [DATA_W-1:0] reg_dat1;
  logic [DATA_W-1:0] reg_dat2;
  logic [DATA_W-1:0] reg_dat3;

  wb_addr_decode i_decode (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_adr_i   (wb_adr_i),
    .reg_ack_i  (reg_ack),
    .reg_dat0_i (reg_dat0),
    .reg_dat1_i (reg_dat1),
    .reg_dat2_i (reg_dat2),
    .reg_dat3_i (reg_dat3),
    .reg_stb_o  (reg_stb),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wb_err_o   (wb_err_o)
  );

  // control words, bus to user
  wb_register_ppc2simulink #(
    .INIT_VAL (CTRL0_INIT)
  ) i_ctrl0 (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .stb_i       (reg_stb[0]),
    .wb_we_i     (wb_we_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_i    (wb_dat_i),
    .user_clk    (user_clk),
    .dat_o       (reg_dat0),
    .ack_o       (reg_ack[0]),
    .user_data_o (ctrl0_o)
  );

  wb_register_ppc2simulink #(
    .INIT_VAL (CTRL1_INIT)
  ) i_ctrl1 (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .stb_i       (reg_stb[1]),
    .wb_we_i     (wb_we_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_i    (wb_dat_i),
    .user_clk    (user_clk),
    .dat_o       (reg_dat1),
    .ack_o       (reg_ack[1]),
    .user_data_o (ctrl1_o)
  );

  // status words, user to bus
  wb_register_simulink2ppc #(
    .INIT_VAL (STAT0_INIT)
  ) i_stat0 (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .stb_i       (reg_stb[2]),
    .user_clk    (user_clk),
    .user_data_i (stat0_i),
    .dat_o       (reg_dat2),
    .ack_o       (reg_ack[2])
  );

  wb_register_simulink2ppc #(
    .INIT_VAL (STAT1_INIT)
  ) i_stat1 (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .stb_i       (reg_stb[3]),
    .user_clk    (user_clk),
    .user_data_i (stat1_i),
    .dat_o       (reg_dat3),
    .ack_o       (reg_ack[3])
  );

endmodule

`default_nettype wire

/* rtl/sw_reg_pkg.sv */
`default_nettype none

package sw_reg_pkg;

  // bus and register widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;

  // byte addresses of the four word registers
  localparam logic [ADDR_W-1:0] ADR_CTRL0 = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] ADR_CTRL1 = 32'h0000_0004;
  localparam logic [ADDR_W-1:0] ADR_STAT0 = 32'h0000_0008;
  localparam logic [ADDR_W-1:0] ADR_STAT1 = 32'h0000_000C;

  // one enable bit per byte lane
  typedef logic [3:0] sel_t;

  // sending side of a crossing, ready is high while waiting for done
  typedef enum logic {
    XFER_IDLE,
    XFER_WAIT_DONE
  } xfer_state_e;

  // receiving side of a crossing, done is high in ACK_HIGH
  typedef enum logic {
    ACK_LOW,
    ACK_HIGH
  } ack_state_e;

endpackage

`default_nettype wire

/* rtl/wb_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode (
  input  wire                          wb_clk_i,
  input  wire                          wb_rst_i,
  input  wire                          wb_cyc_i,
  input  wire                          wb_stb_i,
  input  wire [sw_reg_pkg::ADDR_W-1:0] wb_adr_i,
  input  wire [3:0]                    reg_ack_i,
  input  wire [sw_reg_pkg::DATA_W-1:0] reg_dat0_i,
  input  wire [sw_reg_pkg::DATA_W-1:0] reg_dat1_i,
  input  wire [sw_reg_pkg::DATA_W-1:0] reg_dat2_i,
  input  wire [sw_reg_pkg::DATA_W-1:0] reg_dat3_i,
  output logic [3:0]                   reg_stb_o,
  output logic [sw_reg_pkg::DATA_W-1:0] wb_dat_o,
  output logic                         wb_ack_o,
  output logic                         wb_err_o
);
  import sw_reg_pkg::*;

  logic       req;
  logic [3:0] hit;
  logic       mapped;
  logic       err_q;

  assign req = wb_cyc_i && wb_stb_i;

  // word compare, the two byte offset bits are ignored
  always_comb begin
    hit[0] = (wb_adr_i[ADDR_W-1:2] == ADR_CTRL0[ADDR_W-1:2]);
    hit[1] = (wb_adr_i[ADDR_W-1:2] == ADR_CTRL1[ADDR_W-1:2]);
    hit[2] = (wb_adr_i[ADDR_W-1:2] == ADR_STAT0[ADDR_W-1:2]);
    hit[3] = (wb_adr_i[ADDR_W-1:2] == ADR_STAT1[ADDR_W-1:2]);
  end

  assign mapped    = |hit;
  assign reg_stb_o = req ? hit : 4'b0000;

  // error pulse for unmapped requests
  // no second pulse while the first one is still up
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req && !mapped && !err_q;
    end
  end

  assign wb_err_o = err_q;
  assign wb_ack_o = |reg_ack_i;

  // idle registers drive zero, so a plain OR merges the read data
  assign wb_dat_o = reg_dat0_i | reg_dat1_i | reg_dat2_i | reg_dat3_i;

endmodule

`default_nettype wire

/* rtl/wb_register_ppc2simulink.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_register_ppc2simulink #(
  parameter logic [sw_reg_pkg::DATA_W-1:0] INIT_VAL = '0
) (
  input  wire                           wb_clk_i,
  input  wire                           wb_rst_i,
  input  wire                           stb_i,
  input  wire                           wb_we_i,
  input  wire sw_reg_pkg::sel_t         wb_sel_i,
  input  wire [sw_reg_pkg::DATA_W-1:0]  wb_dat_i,
  input  wire                           user_clk,
  output logic [sw_reg_pkg::DATA_W-1:0] dat_o,
  output logic                          ack_o,
  output logic [sw_reg_pkg::DATA_W-1:0] user_data_o
);
  import sw_reg_pkg::*;

  // bus domain
  logic              ack_q;
  logic              wr_req;
  logic [DATA_W-1:0] reg_buffer;
  xfer_state_e       xfer_state;
  logic              write_pending;
  logic              register_ready;
  logic              done_r;
  logic              done_rr;

  // user domain
  logic              ready_r;
  logic              ready_rr;
  ack_state_e        ack_state;
  logic              register_done;

  assign wr_req = stb_i && wb_we_i && !ack_q;

  // one ack per request, skip a cycle if the strobe is held
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i && !ack_q;
    end
  end

  // byte lane merge, a write during a crossing overwrites in place
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      reg_buffer <= INIT_VAL;
    end else if (wr_req) begin
      for (int i = 0; i < $bits(sel_t); i++) begin
        if (wb_sel_i[i]) begin
          reg_buffer[8*i +: 8] <= wb_dat_i[8*i +: 8];
        end
      end
    end
  end

  // done back into the bus clock
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      done_r  <= 1'b0;
      done_rr <= 1'b0;
    end else begin
      done_r  <= register_done;
      done_rr <= done_r;
    end
  end

  // sender FSM
  // a new ready waits until the previous done has fallen
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      xfer_state    <= XFER_IDLE;
      write_pending <= 1'b0;
    end else begin
      case (xfer_state)
        XFER_IDLE: begin
          if ((wr_req || write_pending) && !done_rr) begin
            xfer_state    <= XFER_WAIT_DONE;
            write_pending <= 1'b0;
          end else if (wr_req) begin
            write_pending <= 1'b1;
          end
        end
        XFER_WAIT_DONE: begin
          if (done_rr) begin
            xfer_state <= XFER_IDLE;
          end
        end
        default: begin
          xfer_state <= XFER_IDLE;
        end
      endcase
    end
  end

  assign register_ready = (xfer_state == XFER_WAIT_DONE);

  // receiver keeps copying while ready is seen, so late writes still land
  always_ff @(posedge user_clk) begin
    if (wb_rst_i) begin
      ready_r     <= 1'b0;
      ready_rr    <= 1'b0;
      ack_state   <= ACK_LOW;
      user_data_o <= INIT_VAL;
    end else begin
      ready_r  <= register_ready;
      ready_rr <= ready_r;
      if (ready_rr) begin
        user_data_o <= reg_buffer;
        ack_state   <= ACK_HIGH;
      end else begin
        ack_state <= ACK_LOW;
      end
    end
  end

  assign register_done = (ack_state == ACK_HIGH);

  assign ack_o = ack_q;
  assign dat_o = ack_q ? reg_buffer : '0;

endmodule

`default_nettype wire

/* rtl/wb_register_simulink2ppc.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_register_simulink2ppc #(
  parameter logic [sw_reg_pkg::DATA_W-1:0] INIT_VAL = '0
) (
  input  wire                           wb_clk_i,
  input  wire                           wb_rst_i,
  input  wire                           stb_i,
  input  wire                           user_clk,
  input  wire [sw_reg_pkg::DATA_W-1:0]  user_data_i,
  output logic [sw_reg_pkg::DATA_W-1:0] dat_o,
  output logic                          ack_o
);
  import sw_reg_pkg::*;

  // user domain
  xfer_state_e       xfer_state;
  logic [DATA_W-1:0] stat_buffer;
  logic              register_ready;
  logic              done_r;
  logic              done_rr;

  // bus domain
  logic              ack_q;
  logic              ready_r;
  logic              ready_rr;
  ack_state_e        ack_state;
  logic              register_done;
  logic [DATA_W-1:0] rd_word;

  // user side sender
  // sample only once the last done has dropped
  always_ff @(posedge user_clk) begin
    if (wb_rst_i) begin
      done_r     <= 1'b0;
      done_rr    <= 1'b0;
      xfer_state <= XFER_IDLE;
    end else begin
      done_r  <= register_done;
      done_rr <= done_r;
      case (xfer_state)
        XFER_IDLE: begin
          if (!done_rr) begin
            xfer_state <= XFER_WAIT_DONE;
          end
        end
        XFER_WAIT_DONE: begin
          if (done_rr) begin
            xfer_state <= XFER_IDLE;
          end
        end
        default: begin
          xfer_state <= XFER_IDLE;
        end
      endcase
    end
  end

  // buffer is frozen while ready is up
  always_ff @(posedge user_clk) begin
    if (xfer_state == XFER_IDLE && !done_rr) begin
      stat_buffer <= user_data_i;
    end
  end

  assign register_ready = (xfer_state == XFER_WAIT_DONE);

  // writes get an ack like reads, the data is dropped
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i && !ack_q;
    end
  end

  // bus side receiver
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ready_r   <= 1'b0;
      ready_rr  <= 1'b0;
      ack_state <= ACK_LOW;
      rd_word   <= INIT_VAL;
    end else begin
      ready_r  <= register_ready;
      ready_rr <= ready_r;
      case (ack_state)
        ACK_LOW: begin
          if (ready_rr) begin
            rd_word   <= stat_buffer;
            ack_state <= ACK_HIGH;
          end
        end
        ACK_HIGH: begin
          if (!ready_rr) begin
            ack_state <= ACK_LOW;
          end
        end
        default: begin
          ack_state <= ACK_LOW;
        end
      endcase
    end
  end

  assign register_done = (ack_state == ACK_HIGH);

  assign ack_o = ack_q;
  assign dat_o = ack_q ? rd_word : '0;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the register bank testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f vlog.f --top-module tb_sw_reg_bank -o tb_sw_reg_bank

sim_out=$(./obj_dir/tb_sw_reg_bank)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'No errors'; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

/* vlog.f */
rtl/sw_reg_pkg.sv
rtl/wb_addr_decode.sv
rtl/wb_register_ppc2simulink.sv
rtl/wb_register_simulink2ppc.sv
rtl/sw_reg_bank_top.sv
dv/tb_sw_reg_bank.sv
